// File: Bender.yml
package:
  name: mips_lite

sources:
  - hdl/mips_pkg.sv
  - hdl/alu.sv
  - hdl/reg_file.sv
  - hdl/decode.sv
  - hdl/fetch_unit.sv
  - hdl/load_store_unit.sv
  - hdl/bus_arbiter.sv
  - hdl/mips_lite.sv
  - target: test
    files:
      - tests/mips_lite_properties.sv
      - tests/tb_mips_lite.sv

// File: hdl/alu.sv
`timescale 1ns/1ns

module alu (
    input  mips_pkg::alu_op_t alu_op,
    input  mips_pkg::data_t   operand_1,
    input  mips_pkg::data_t   operand_2,
    output mips_pkg::data_t   result
);

    always_comb begin
        case (alu_op)
            mips_pkg::alu_add: begin
                // also the load/store effective address
                result = operand_1 + operand_2;
            end
            mips_pkg::alu_sub: begin
                result = operand_1 - operand_2;
            end
            mips_pkg::alu_and: begin
                result = operand_1 & operand_2;
            end
            mips_pkg::alu_or: begin
                result = operand_1 | operand_2;
            end
            mips_pkg::alu_slt: begin
                result = {31'b0, $signed(operand_1) < $signed(operand_2)};
            end
            mips_pkg::alu_lui_pass: begin
                result = operand_2;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: hdl/bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter (
    input  logic            clk,
    input  logic            rst,
    input  logic            f_req,
    input  mips_pkg::addr_t f_addr,
    output logic            f_gnt_done,
    output mips_pkg::data_t f_rdata,
    input  logic            d_req,
    input  mips_pkg::addr_t d_addr,
    input  logic            d_write,
    input  mips_pkg::data_t d_wdata,
    output logic            d_gnt_done,
    output mips_pkg::data_t d_rdata,
    output mips_pkg::addr_t paddr,
    output logic            psel,
    output logic            penable,
    output logic            pwrite,
    output mips_pkg::data_t pwdata,
    output logic [2:0]      pprot,
    input  mips_pkg::data_t prdata,
    input  logic            pready
);

    mips_pkg::arb_state_t state;
    logic                 sel_data;
    logic                 done;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= mips_pkg::arb_idle;
            sel_data <= 1'b0;
        end else begin
            case (state)
                mips_pkg::arb_idle: begin
                    // data side wins a tie
                    if (d_req || f_req) begin
                        sel_data <= d_req;
                        state    <= mips_pkg::arb_setup;
                    end
                end
                mips_pkg::arb_setup: state <= mips_pkg::arb_access;
                mips_pkg::arb_access: begin
                    if (pready) begin
                        state <= mips_pkg::arb_idle;
                    end
                end
                default: state <= mips_pkg::arb_idle;
            endcase
        end
    end

    assign done       = (state == mips_pkg::arb_access) && pready;
    assign f_gnt_done = done && !sel_data;
    assign d_gnt_done = done && sel_data;
    assign f_rdata    = prdata;
    assign d_rdata    = prdata;

    // requesters hold their inputs until gnt_done, so these stay stable
    assign psel    = (state != mips_pkg::arb_idle);
    assign penable = (state == mips_pkg::arb_access);
    assign paddr   = sel_data ? d_addr : f_addr;
    assign pwrite  = sel_data && d_write;
    assign pwdata  = d_wdata;
    assign pprot   = {!sel_data, 2'b00};

endmodule

// File: hdl/decode.sv
`timescale 1ns/1ns

module decode (
    input  logic                rst,
    input  mips_pkg::inst_t     inst,
    input  mips_pkg::addr_t     inst_addr,
    input  mips_pkg::data_t     reg_data_1,
    input  mips_pkg::data_t     reg_data_2,
    output mips_pkg::reg_addr_t reg_addr_1,
    output mips_pkg::reg_addr_t reg_addr_2,
    output mips_pkg::alu_op_t   alu_op,
    output mips_pkg::data_t     operand_1,
    output mips_pkg::data_t     operand_2,
    output logic                branch_flag,
    output mips_pkg::addr_t     branch_addr,
    output logic                mem_read_flag,
    output logic                mem_write_flag,
    output mips_pkg::data_t     mem_write_data,
    output logic                write_reg_en,
    output mips_pkg::reg_addr_t write_reg_addr
);

    logic [5:0]          op;
    logic [5:0]          funct;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t rd;
    mips_pkg::data_t     imm_sext;
    mips_pkg::data_t     imm_zext;
    mips_pkg::data_t     imm_hi;
    mips_pkg::addr_t     pc_plus_4;
    mips_pkg::addr_t     br_target;
    mips_pkg::addr_t     jump_target;

    assign op    = inst[31:26];
    assign rs    = inst[25:21];
    assign rt    = inst[20:16];
    assign rd    = inst[15:11];
    assign funct = inst[5:0];

    assign imm_sext    = {{16{inst[15]}}, inst[15:0]};
    assign imm_zext    = {16'b0, inst[15:0]};
    assign imm_hi      = {inst[15:0], 16'b0};
    assign pc_plus_4   = inst_addr + 32'd4;
    assign br_target   = pc_plus_4 + {imm_sext[29:0], 2'b00};
    assign jump_target = {pc_plus_4[31:28], inst[25:0], 2'b00};

    always_comb begin
        reg_addr_1     = '0;
        reg_addr_2     = '0;
        alu_op         = mips_pkg::alu_add;
        operand_1      = '0;
        operand_2      = '0;
        branch_flag    = 1'b0;
        branch_addr    = '0;
        mem_read_flag  = 1'b0;
        mem_write_flag = 1'b0;
        mem_write_data = '0;
        write_reg_en   = 1'b0;
        write_reg_addr = '0;
        if (rst) begin
            case (op)
                mips_pkg::op_special: begin
                    reg_addr_1     = rs;
                    reg_addr_2     = rt;
                    operand_1      = reg_data_1;
                    operand_2      = reg_data_2;
                    write_reg_addr = rd;
                    write_reg_en   = 1'b1;
                    case (funct)
                        mips_pkg::funct_addu: alu_op = mips_pkg::alu_add;
                        mips_pkg::funct_subu: alu_op = mips_pkg::alu_sub;
                        mips_pkg::funct_and:  alu_op = mips_pkg::alu_and;
                        mips_pkg::funct_or:   alu_op = mips_pkg::alu_or;
                        mips_pkg::funct_slt:  alu_op = mips_pkg::alu_slt;
                        mips_pkg::funct_jr: begin
                            write_reg_en = 1'b0;
                            branch_flag  = 1'b1;
                            branch_addr  = reg_data_1;
                        end
                        default: write_reg_en = 1'b0;
                    endcase
                end
                mips_pkg::op_addiu, mips_pkg::op_slti, mips_pkg::op_ori: begin
                    reg_addr_1     = rs;
                    operand_1      = reg_data_1;
                    operand_2      = (op == mips_pkg::op_ori) ? imm_zext : imm_sext;
                    write_reg_en   = 1'b1;
                    write_reg_addr = rt;
                    if (op == mips_pkg::op_ori) begin
                        alu_op = mips_pkg::alu_or;
                    end else if (op == mips_pkg::op_slti) begin
                        alu_op = mips_pkg::alu_slt;
                    end
                end
                mips_pkg::op_lui: begin
                    alu_op         = mips_pkg::alu_lui_pass;
                    operand_2      = imm_hi;
                    write_reg_en   = 1'b1;
                    write_reg_addr = rt;
                end
                mips_pkg::op_lw: begin
                    // load_store_unit owns the write back of rt
                    reg_addr_1     = rs;
                    operand_1      = reg_data_1;
                    operand_2      = imm_sext;
                    mem_read_flag  = 1'b1;
                    write_reg_addr = rt;
                end
                mips_pkg::op_sw: begin
                    reg_addr_1     = rs;
                    reg_addr_2     = rt;
                    operand_1      = reg_data_1;
                    operand_2      = imm_sext;
                    mem_write_flag = 1'b1;
                    mem_write_data = reg_data_2;
                end
                mips_pkg::op_beq, mips_pkg::op_bne: begin
                    reg_addr_1 = rs;
                    reg_addr_2 = rt;
                    if ((reg_data_1 == reg_data_2) == (op == mips_pkg::op_beq)) begin
                        branch_flag = 1'b1;
                        branch_addr = br_target;
                    end
                end
                mips_pkg::op_j: begin
                    branch_flag = 1'b1;
                    branch_addr = jump_target;
                end
                default: begin
                    // unsupported opcode, retire as no-op
                    write_reg_en = 1'b0;
                end
            endcase
        end
    end

endmodule

// File: hdl/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit #(
    parameter mips_pkg::addr_t reset_vector = 32'h0
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            consume,
    input  logic            branch_flag,
    input  mips_pkg::addr_t branch_addr,
    output logic            inst_valid,
    output mips_pkg::inst_t inst,
    output mips_pkg::addr_t inst_addr,
    output logic            req,
    output mips_pkg::addr_t addr,
    input  logic            gnt_done,
    input  mips_pkg::data_t rdata
);

    mips_pkg::fetch_state_t state;
    mips_pkg::addr_t        pc;
    mips_pkg::addr_t        fetch_addr;
    mips_pkg::inst_t        q_inst [2];
    mips_pkg::addr_t        q_addr [2];
    logic [1:0]             count;
    logic                   stale;
    logic                   redirect;
    logic                   push;
    logic                   issue;
    logic                   wr_hi;

    assign redirect = consume && branch_flag;
    // word from the bus is dropped if it belongs to an abandoned path
    assign push     = gnt_done && !stale && !redirect;
    assign issue    = (state == mips_pkg::fetch_idle) && !redirect && (count != 2'd2);
    assign wr_hi    = !consume && (count == 2'd1);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= mips_pkg::fetch_idle;
            pc    <= reset_vector;
            count <= 2'd0;
            stale <= 1'b0;
        end else begin
            if (redirect) begin
                pc    <= branch_addr;
                count <= 2'd0;
                if (state == mips_pkg::fetch_busy && !gnt_done) begin
                    stale <= 1'b1;
                end
            end else if (push && !consume) begin
                count <= count + 2'd1;
            end else if (consume && !push) begin
                count <= count - 2'd1;
            end
            if (gnt_done) begin
                state <= mips_pkg::fetch_idle;
                stale <= 1'b0;
            end else if (issue) begin
                state <= mips_pkg::fetch_busy;
                pc    <= pc + 32'd4;
            end
        end
    end

    // queue shifts toward slot 0 on consume
    always_ff @(posedge clk) begin
        if (issue) begin
            fetch_addr <= pc;
        end
        if (consume) begin
            q_inst[0] <= q_inst[1];
            q_addr[0] <= q_addr[1];
        end
        if (push) begin
            q_inst[wr_hi] <= rdata;
            q_addr[wr_hi] <= fetch_addr;
        end
    end

    assign inst_valid = (count != 2'd0);
    assign inst       = q_inst[0];
    assign inst_addr  = q_addr[0];
    assign req        = (state == mips_pkg::fetch_busy);
    assign addr       = fetch_addr;

endmodule

// File: hdl/load_store_unit.sv
`timescale 1ns/1ns

module load_store_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  logic                mem_read_flag,
    input  logic                mem_write_flag,
    input  mips_pkg::addr_t     mem_addr,
    input  mips_pkg::data_t     store_data,
    input  mips_pkg::reg_addr_t load_reg,
    output logic                lsu_busy,
    output logic                req,
    output mips_pkg::addr_t     addr,
    output logic                write,
    output mips_pkg::data_t     wdata,
    input  logic                gnt_done,
    input  mips_pkg::data_t     rdata,
    output logic                wb_en,
    output mips_pkg::reg_addr_t wb_addr,
    output mips_pkg::data_t     wb_data
);

    logic                busy;
    logic                is_store;
    logic                launch;
    mips_pkg::addr_t     addr_q;
    mips_pkg::data_t     data_q;
    mips_pkg::reg_addr_t reg_q;

    assign launch = start && (mem_read_flag || mem_write_flag);

    // busy stays high through the gnt_done cycle
    always_ff @(posedge clk) begin
        if (!rst) begin
            busy     <= 1'b0;
            is_store <= 1'b0;
        end else if (launch) begin
            busy     <= 1'b1;
            is_store <= mem_write_flag;
        end else if (gnt_done) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            addr_q <= mem_addr;
            data_q <= store_data;
            reg_q  <= load_reg;
        end
    end

    assign lsu_busy = busy;
    assign req      = busy;
    assign addr     = addr_q;
    assign write    = is_store;
    assign wdata    = data_q;
    assign wb_en    = busy && gnt_done && !is_store;
    assign wb_addr  = reg_q;
    assign wb_data  = rdata;

endmodule

// File: hdl/mips_lite.sv
`timescale 1ns/1ns

module mips_lite #(
    parameter mips_pkg::addr_t reset_vector = 32'h0
) (
    input  logic            clk,
    input  logic            rst,
    output mips_pkg::addr_t paddr,
    output logic            psel,
    output logic            penable,
    output logic            pwrite,
    output mips_pkg::data_t pwdata,
    output logic [2:0]      pprot,
    input  mips_pkg::data_t prdata,
    input  logic            pready
);

    logic                inst_valid;
    mips_pkg::inst_t     inst;
    mips_pkg::addr_t     inst_addr;
    logic                lsu_busy;
    logic                branch_flag;
    mips_pkg::addr_t     branch_addr;
    mips_pkg::reg_addr_t reg_addr_1;
    mips_pkg::reg_addr_t reg_addr_2;
    mips_pkg::data_t     reg_data_1;
    mips_pkg::data_t     reg_data_2;
    mips_pkg::alu_op_t   alu_op;
    mips_pkg::data_t     operand_1;
    mips_pkg::data_t     operand_2;
    mips_pkg::data_t     alu_result;
    logic                mem_read_flag;
    logic                mem_write_flag;
    mips_pkg::data_t     mem_write_data;
    logic                write_reg_en;
    mips_pkg::reg_addr_t write_reg_addr;
    logic                wb_en;
    mips_pkg::reg_addr_t wb_addr;
    mips_pkg::data_t     wb_data;
    logic                f_req;
    mips_pkg::addr_t     f_addr;
    logic                f_gnt_done;
    mips_pkg::data_t     f_rdata;
    logic                d_req;
    mips_pkg::addr_t     d_addr;
    logic                d_write;
    mips_pkg::data_t     d_wdata;
    logic                d_gnt_done;
    mips_pkg::data_t     d_rdata;

    // head retires when the lsu is free
    wire consume = inst_valid && !lsu_busy;

    // load data beats alu result on the single write port
    wire                 rf_write_en   = wb_en || (write_reg_en && consume);
    mips_pkg::reg_addr_t rf_write_addr;
    mips_pkg::data_t     rf_write_data;
    assign rf_write_addr = wb_en ? wb_addr : write_reg_addr;
    assign rf_write_data = wb_en ? wb_data : alu_result;

    fetch_unit #(
        .reset_vector(reset_vector)
    ) fetch_unit_inst (
        .clk        (clk),
        .rst        (rst),
        .consume    (consume),
        .branch_flag(branch_flag),
        .branch_addr(branch_addr),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_addr  (inst_addr),
        .req        (f_req),
        .addr       (f_addr),
        .gnt_done   (f_gnt_done),
        .rdata      (f_rdata)
    );

    decode decode_inst (
        .rst           (rst),
        .inst          (inst),
        .inst_addr     (inst_addr),
        .reg_data_1    (reg_data_1),
        .reg_data_2    (reg_data_2),
        .reg_addr_1    (reg_addr_1),
        .reg_addr_2    (reg_addr_2),
        .alu_op        (alu_op),
        .operand_1     (operand_1),
        .operand_2     (operand_2),
        .branch_flag   (branch_flag),
        .branch_addr   (branch_addr),
        .mem_read_flag (mem_read_flag),
        .mem_write_flag(mem_write_flag),
        .mem_write_data(mem_write_data),
        .write_reg_en  (write_reg_en),
        .write_reg_addr(write_reg_addr)
    );

    alu alu_inst (
        .alu_op   (alu_op),
        .operand_1(operand_1),
        .operand_2(operand_2),
        .result   (alu_result)
    );

    reg_file reg_file_inst (
        .clk        (clk),
        .rst        (rst),
        .read_addr_1(reg_addr_1),
        .read_addr_2(reg_addr_2),
        .read_data_1(reg_data_1),
        .read_data_2(reg_data_2),
        .write_en   (rf_write_en),
        .write_addr (rf_write_addr),
        .write_data (rf_write_data)
    );

    load_store_unit load_store_unit_inst (
        .clk           (clk),
        .rst           (rst),
        .start         (consume),
        .mem_read_flag (mem_read_flag),
        .mem_write_flag(mem_write_flag),
        .mem_addr      (alu_result),
        .store_data    (mem_write_data),
        .load_reg      (write_reg_addr),
        .lsu_busy      (lsu_busy),
        .req           (d_req),
        .addr          (d_addr),
        .write         (d_write),
        .wdata         (d_wdata),
        .gnt_done      (d_gnt_done),
        .rdata         (d_rdata),
        .wb_en         (wb_en),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data)
    );

    bus_arbiter bus_arbiter_inst (
        .clk       (clk),
        .rst       (rst),
        .f_req     (f_req),
        .f_addr    (f_addr),
        .f_gnt_done(f_gnt_done),
        .f_rdata   (f_rdata),
        .d_req     (d_req),
        .d_addr    (d_addr),
        .d_write   (d_write),
        .d_wdata   (d_wdata),
        .d_gnt_done(d_gnt_done),
        .d_rdata   (d_rdata),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .pprot     (pprot),
        .prdata    (prdata),
        .pready    (pready)
    );

endmodule

// File: hdl/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [2:0] {
        alu_add      = 3'd0,
        alu_sub      = 3'd1,
        alu_and      = 3'd2,
        alu_or       = 3'd3,
        alu_slt      = 3'd4,
        alu_lui_pass = 3'd5
    } alu_op_t;

    typedef enum logic [1:0] {
        arb_idle,
        arb_setup,
        arb_access
    } arb_state_t;

    typedef enum logic {
        fetch_idle,
        fetch_busy
    } fetch_state_t;

    // primary opcodes, inst[31:26]
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // special group, inst[5:0]
    localparam logic [5:0] funct_jr   = 6'h08;
    localparam logic [5:0] funct_addu = 6'h21;
    localparam logic [5:0] funct_subu = 6'h23;
    localparam logic [5:0] funct_and  = 6'h24;
    localparam logic [5:0] funct_or   = 6'h25;
    localparam logic [5:0] funct_slt  = 6'h2a;

endpackage

// File: hdl/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic                clk,
    input  logic                rst,
    input  mips_pkg::reg_addr_t read_addr_1,
    input  mips_pkg::reg_addr_t read_addr_2,
    output mips_pkg::data_t     read_data_1,
    output mips_pkg::data_t     read_data_2,
    input  logic                write_en,
    input  mips_pkg::reg_addr_t write_addr,
    input  mips_pkg::data_t     write_data
);

    mips_pkg::data_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && write_addr != 5'd0) begin
            regs[write_addr] <= write_data;
        end
    end

    // $zero always reads zero
    assign read_data_1 = (read_addr_1 == 5'd0) ? '0 : regs[read_addr_1];
    assign read_data_2 = (read_addr_2 == 5'd0) ? '0 : regs[read_addr_2];

endmodule

// File: mips_lite.f
hdl/mips_pkg.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/decode.sv
hdl/fetch_unit.sv
hdl/load_store_unit.sv
hdl/bus_arbiter.sv
hdl/mips_lite.sv
tests/mips_lite_properties.sv
tests/tb_mips_lite.sv

// File: tests/mips_lite_properties.sv
`timescale 1ns/1ns

module mips_lite_properties #(
    parameter mips_pkg::addr_t reset_vector = 32'h0,
    parameter mips_pkg::addr_t poison_addr  = 32'h3f0
) (
    input logic            clk,
    input logic            rst,
    input mips_pkg::addr_t paddr,
    input logic            psel,
    input logic            penable,
    input logic            pwrite,
    input mips_pkg::data_t pwdata,
    input logic [2:0]      pprot,
    input logic            pready,
    input logic            consume,
    input logic            branch_flag,
    input logic            inst_valid,
    input logic            d_gnt_done
);

    int   fail_count = 0;
    logic first_done;

    // goes high once the first transfer has been seen
    always_ff @(posedge clk) begin
        if (!rst) begin
            first_done <= 1'b0;
        end else if (psel) begin
            first_done <= 1'b1;
        end
    end

    a_reset_idle: assert property (@(posedge clk) !rst |=> (!psel && !penable))
        else begin fail_count++; $error("bus not idle after reset"); end

    a_first_fetch: assert property (@(posedge clk) disable iff (!rst)
        (psel && !first_done) |-> (pprot[2] && paddr == reset_vector))
        else begin fail_count++; $error("first transfer is not a fetch from reset_vector"); end

    a_setup_access: assert property (@(posedge clk) disable iff (!rst)
        (psel && !penable) |=> (psel && penable))
        else begin fail_count++; $error("setup phase not followed by access"); end

    a_access_sel: assert property (@(posedge clk) disable iff (!rst) penable |-> psel)
        else begin fail_count++; $error("penable high without psel"); end

    // request fields hold from setup until pready
    a_stable: assert property (@(posedge clk) disable iff (!rst)
        (psel && !(penable && pready)) |=> ($stable(paddr) && $stable(pwrite)
            && $stable(pprot) && (!pwrite || $stable(pwdata))))
        else begin fail_count++; $error("APB request changed before pready"); end

    a_idle_gap: assert property (@(posedge clk) disable iff (!rst)
        (penable && pready) |=> !psel)
        else begin fail_count++; $error("no idle cycle after a completed transfer"); end

    a_fetch_read: assert property (@(posedge clk) disable iff (!rst)
        (psel && pprot[2]) |-> !pwrite)
        else begin fail_count++; $error("instruction fetch issued as a write"); end

    a_data_prot: assert property (@(posedge clk) disable iff (!rst) d_gnt_done |-> !pprot[2])
        else begin fail_count++; $error("data transfer marked as instruction access"); end

    a_no_poison: assert property (@(posedge clk) disable iff (!rst)
        (psel && pwrite) |-> (paddr != poison_addr))
        else begin fail_count++; $error("write to a skipped poison address"); end

    // queue empties after a taken branch or jump
    a_redirect_flush: assert property (@(posedge clk) disable iff (!rst)
        (consume && branch_flag) |=> !inst_valid)
        else begin fail_count++; $error("instruction queue not flushed on redirect"); end

endmodule

// File: tests/tb_mips_lite.sv
`timescale 1ns/1ns

module tb_mips_lite;

    localparam mips_pkg::addr_t reset_vector = 32'h0000_0000;
    localparam mips_pkg::addr_t done_addr    = 32'h0000_03fc;
    localparam mips_pkg::data_t load_value   = 32'h1357_9bdf;
    localparam int              timeout      = 5000;

    logic            clk;
    logic            rst;
    mips_pkg::addr_t paddr;
    logic            psel;
    logic            penable;
    logic            pwrite;
    mips_pkg::data_t pwdata;
    logic [2:0]      pprot;
    mips_pkg::data_t prdata;
    logic            pready;

    mips_pkg::data_t mem [256];
    mips_pkg::data_t exp_val [mips_pkg::addr_t];
    int              seen [mips_pkg::addr_t];
    int              wait_left;
    int              errors;
    int              cycles;
    logic            done_seen;

    mips_lite #(
        .reset_vector(reset_vector)
    ) mips_lite_inst (
        .clk    (clk),
        .rst    (rst),
        .paddr  (paddr),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .pwdata (pwdata),
        .pprot  (pprot),
        .prdata (prdata),
        .pready (pready)
    );

    bind mips_lite mips_lite_properties #(
        .reset_vector(32'h0000_0000),
        .poison_addr (32'h0000_03f0)
    ) props_inst (
        .clk        (clk),
        .rst        (rst),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .pprot      (pprot),
        .pready     (pready),
        .consume    (consume),
        .branch_flag(branch_flag),
        .inst_valid (inst_valid),
        .d_gnt_done (d_gnt_done)
    );

    always #20 clk = ~clk;

    function automatic mips_pkg::inst_t assemble_r(input logic [5:0] funct, input int rs,
                                                   input int rt, input int rd);
        return {mips_pkg::op_special, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
    endfunction

    function automatic mips_pkg::inst_t assemble_i(input logic [5:0] op, input int rs,
                                                   input int rt, input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic mips_pkg::inst_t assemble_j(input int target_word);
        return {mips_pkg::op_j, 26'(target_word)};
    endfunction

    task automatic load_program();
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h5a5a_0000 ^ (i * 4);
        end
        mem[128] = load_value;
        mem[0]  = assemble_i(mips_pkg::op_addiu, 0, 1, 16'h1234);
        mem[1]  = assemble_i(mips_pkg::op_ori, 0, 2, 16'h8001);
        mem[2]  = assemble_i(mips_pkg::op_lui, 0, 3, 16'habcd);
        mem[3]  = assemble_i(mips_pkg::op_addiu, 0, 4, 16'hfffd);
        mem[4]  = assemble_r(mips_pkg::funct_addu, 1, 2, 5);
        mem[5]  = assemble_r(mips_pkg::funct_subu, 1, 4, 6);
        mem[6]  = assemble_r(mips_pkg::funct_and, 5, 6, 7);
        mem[7]  = assemble_r(mips_pkg::funct_or, 3, 1, 8);
        mem[8]  = assemble_r(mips_pkg::funct_slt, 4, 1, 9);
        mem[9]  = assemble_r(mips_pkg::funct_slt, 1, 4, 10);
        // results r1..r10 to 0x300..0x324
        for (int r = 1; r <= 10; r++) begin
            mem[9 + r] = assemble_i(mips_pkg::op_sw, 0, r, 16'(32'h2fc + 4 * r));
        end
        mem[20] = assemble_i(mips_pkg::op_lw, 0, 11, 16'h0200);
        mem[21] = assemble_i(mips_pkg::op_addiu, 11, 11, 16'h0001);
        mem[22] = assemble_i(mips_pkg::op_sw, 0, 11, 16'h0328);
        // taken beq skips one poison store
        mem[23] = assemble_i(mips_pkg::op_beq, 1, 1, 16'h0001);
        mem[24] = assemble_i(mips_pkg::op_sw, 0, 0, 16'h03f0);
        mem[25] = assemble_i(mips_pkg::op_bne, 1, 1, 16'h0001);
        mem[26] = assemble_i(mips_pkg::op_sw, 0, 1, 16'h032c);
        mem[27] = assemble_j(29);
        mem[28] = assemble_i(mips_pkg::op_sw, 0, 0, 16'h03f0);
        mem[29] = assemble_i(mips_pkg::op_addiu, 0, 12, 16'h0080);
        mem[30] = assemble_r(mips_pkg::funct_jr, 12, 0, 0);
        mem[31] = assemble_i(mips_pkg::op_sw, 0, 0, 16'h03f0);
        mem[32] = assemble_i(mips_pkg::op_addiu, 0, 13, 16'h0001);
        mem[33] = assemble_i(mips_pkg::op_sw, 0, 13, 16'h03fc);
        mem[34] = assemble_j(34);
    endtask

    task automatic build_expected();
        mips_pkg::data_t r [1:10];
        r[1]  = 32'h0000_1234;
        r[2]  = 32'h0000_8001;
        r[3]  = 32'habcd_0000;
        r[4]  = 32'hffff_fffd;
        // 0x1234 + 0x8001
        r[5]  = 32'h0000_9235;
        // 0x1234 minus -3
        r[6]  = 32'h0000_1237;
        r[7]  = 32'h0000_1235;
        r[8]  = 32'habcd_1234;
        // -3 is below 0x1234 only when signed
        r[9]  = 32'd1;
        r[10] = 32'd0;
        for (int i = 1; i <= 10; i++) begin
            exp_val[32'h2fc + 4 * i] = r[i];
        end
        exp_val[32'h328] = load_value + 32'd1;
        exp_val[32'h32c] = r[1];
    endtask

    task automatic check_store();
        if (paddr == done_addr) begin
            assert (pwdata == 32'd1) else begin
                errors++;
                $display("FAILED %0t pwdata @%h: got %h, expected %h",
                         $time, paddr, pwdata, 32'd1);
            end
            done_seen <= 1'b1;
        end else begin
            assert (exp_val.exists(paddr)) else begin
                errors++;
                $display("store to an address outside the result table: %h at %0t",
                         paddr, $time);
            end
            if (exp_val.exists(paddr)) begin
                assert (pwdata == exp_val[paddr]) else begin
                    errors++;
                    $display("FAILED %0t pwdata @%h: got %h, expected %h",
                             $time, paddr, pwdata, exp_val[paddr]);
                end
                seen[paddr] = seen.exists(paddr) ? seen[paddr] + 1 : 1;
            end
        end
    endtask

    // behavioural APB memory with random wait states
    always @(posedge clk) begin
        if (!rst) begin
            pready    <= 1'b0;
            wait_left <= 0;
        end else if (psel && !penable) begin
            assert (paddr[31:10] == '0) else begin
                errors++;
                $display("APB access outside the memory model: %h at %0t", paddr, $time);
            end
            wait_left <= $urandom % 4;
        end else if (psel && penable && pready) begin
            pready <= 1'b0;
            if (pwrite) begin
                check_store();
                mem[paddr[9:2]] <= pwdata;
            end
        end else if (psel && penable) begin
            if (wait_left == 0) begin
                pready <= 1'b1;
                prdata <= mem[paddr[9:2]];
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

    initial begin
        void'($urandom(32'hd297));
        clk       = 1'b0;
        rst       = 1'b0;
        prdata    = '0;
        pready    = 1'b0;
        errors    = 0;
        done_seen = 1'b0;
        load_program();
        build_expected();
        repeat (10) @(posedge clk);
        rst <= 1'b1;

        cycles = 0;
        while (!done_seen && cycles < timeout) begin
            @(posedge clk);
            cycles++;
        end
        assert (done_seen) else begin
            errors++;
            $display("timeout: no store to the done address within %0d cycles", timeout);
        end
        // let trailing transfers settle
        repeat (8) @(posedge clk);

        foreach (exp_val[a]) begin
            assert (seen.exists(a) && seen[a] == 1) else begin
                errors++;
                $display("FAILED %0t store count @%h: got %0d, expected 1",
                         $time, a, seen.exists(a) ? seen[a] : 0);
            end
        end

        $display("errors: %0d testbench, %0d assertion",
                 errors, mips_lite_inst.props_inst.fail_count);
        if (errors == 0 && mips_lite_inst.props_inst.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
